// ==== Bender.yml ====
package:
  name: decode_front

sources:
  - common/mips_pkg.sv
  - decode/main_decoder.sv
  - decode/decode_stage.sv
  - verilog/fetch_unit.sv
  - verilog/instr_queue.sv
  - verilog/decode_front.sv
  - target: test
    files:
      - sim/tb_decode_front.sv

// ==== common/mips_pkg.sv ====
package mips_pkg;

    // one word, two decodes
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_word_t;

    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_BLEZ  = 6'b000110;
    localparam logic [5:0] OP_BGTZ  = 6'b000111;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_SLTIU = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_FP    = 6'b010001;
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LH    = 6'b100001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_LBU   = 6'b100100;
    localparam logic [5:0] OP_LHU   = 6'b100101;
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SH    = 6'b101001;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_LWC1  = 6'b110001;
    localparam logic [5:0] OP_SWC1  = 6'b111001;

    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_FADD = 6'b000000;
    localparam logic [5:0] FN_FSUB = 6'b000001;
    localparam logic [5:0] FN_FMUL = 6'b000010;
    localparam logic [5:0] FN_FDIV = 6'b000011;

    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_RTYPE = 4'd1; // alu decodes funct
    localparam logic [3:0] ALU_SLT   = 4'd2;
    localparam logic [3:0] ALU_SLTU  = 4'd3;
    localparam logic [3:0] ALU_AND   = 4'd4;
    localparam logic [3:0] ALU_OR    = 4'd5;
    localparam logic [3:0] ALU_XOR   = 4'd6;
    localparam logic [3:0] ALU_LUI   = 4'd7;
    localparam logic [3:0] ALU_LEZ   = 4'd8;
    localparam logic [3:0] ALU_GTZ   = 4'd9;

    localparam logic [3:0] FP_NONE = 4'd0;
    localparam logic [3:0] FP_ADD  = 4'd1;
    localparam logic [3:0] FP_SUB  = 4'd2;
    localparam logic [3:0] FP_MUL  = 4'd3;
    localparam logic [3:0] FP_DIV  = 4'd4;

    localparam logic [1:0] SIZE_NONE = 2'd0;
    localparam logic [1:0] SIZE_WORD = 2'd1;
    localparam logic [1:0] SIZE_HALF = 2'd2;
    localparam logic [1:0] SIZE_BYTE = 2'd3;

endpackage

// ==== decode/decode_stage.sv ====
module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  hold,
    input  logic                  empty,
    input  mips_pkg::instr_word_t pop_instr,
    input  logic [31:0]           pop_pc,
    output logic                  pop,
    output logic                  dec_valid,
    output logic [31:0]           dec_pc,
    output logic [4:0]            rs,
    output logic [4:0]            rt,
    output logic [4:0]            dest,
    output logic [31:0]           imm,
    output logic                  reg_write,
    output logic                  reg_dst,
    output logic [1:0]            alu_src,
    output logic                  branch,
    output logic                  branch_ne,
    output logic [1:0]            mem_size_wr,
    output logic                  mem_to_reg,
    output logic [1:0]            mem_size_rd,
    output logic                  load_unsigned,
    output logic                  jump,
    output logic                  jump_reg,
    output logic                  link,
    output logic [3:0]            alu_op,
    output logic [3:0]            fp_op,
    output logic                  fp_reg_write,
    output logic                  fp_mem_write,
    output logic                  mem_to_fp,
    output logic                  illegal
);
    import mips_pkg::*;

    logic        d_reg_write;
    logic        d_reg_dst;
    logic [1:0]  d_alu_src;
    logic        d_branch;
    logic        d_branch_ne;
    logic [1:0]  d_mem_size_wr;
    logic        d_mem_to_reg;
    logic [1:0]  d_mem_size_rd;
    logic        d_load_unsigned;
    logic        d_jump;
    logic        d_jump_reg;
    logic        d_link;
    logic [3:0]  d_alu_op;
    logic [3:0]  d_fp_op;
    logic        d_fp_reg_write;
    logic        d_fp_mem_write;
    logic        d_mem_to_fp;
    logic        d_illegal;
    logic [4:0]  d_dest;
    logic [31:0] d_imm;

    assign pop = !empty && !hold;

    main_decoder main_decoder_i (
        .op            (pop_instr.r.op),
        .funct         (pop_instr.r.funct),
        .reg_write     (d_reg_write),
        .reg_dst       (d_reg_dst),
        .alu_src       (d_alu_src),
        .branch        (d_branch),
        .branch_ne     (d_branch_ne),
        .mem_size_wr   (d_mem_size_wr),
        .mem_to_reg    (d_mem_to_reg),
        .mem_size_rd   (d_mem_size_rd),
        .load_unsigned (d_load_unsigned),
        .jump          (d_jump),
        .jump_reg      (d_jump_reg),
        .link          (d_link),
        .alu_op        (d_alu_op),
        .fp_op         (d_fp_op),
        .fp_reg_write  (d_fp_reg_write),
        .fp_mem_write  (d_fp_mem_write),
        .mem_to_fp     (d_mem_to_fp),
        .illegal       (d_illegal)
    );

    // jalr sets reg_dst, jal only links
    assign d_dest = d_reg_dst ? pop_instr.r.rd :
                    d_link    ? 5'd31 : pop_instr.r.rt;

    always_comb begin
        if (d_alu_op == ALU_LUI) begin
            d_imm = {pop_instr.i.imm, 16'h0000};
        end else if (d_alu_src == 2'd2) begin
            d_imm = {16'h0000, pop_instr.i.imm};
        end else begin
            d_imm = {{16{pop_instr.i.imm[15]}}, pop_instr.i.imm};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= pop && !flush; // redirect kills the popped word
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_pc        <= pop_pc;
            rs            <= pop_instr.r.rs;
            rt            <= pop_instr.r.rt;
            dest          <= d_dest;
            imm           <= d_imm;
            reg_write     <= d_reg_write;
            reg_dst       <= d_reg_dst;
            alu_src       <= d_alu_src;
            branch        <= d_branch;
            branch_ne     <= d_branch_ne;
            mem_size_wr   <= d_mem_size_wr;
            mem_to_reg    <= d_mem_to_reg;
            mem_size_rd   <= d_mem_size_rd;
            load_unsigned <= d_load_unsigned;
            jump          <= d_jump;
            jump_reg      <= d_jump_reg;
            link          <= d_link;
            alu_op        <= d_alu_op;
            fp_op         <= d_fp_op;
            fp_reg_write  <= d_fp_reg_write;
            fp_mem_write  <= d_fp_mem_write;
            mem_to_fp     <= d_mem_to_fp;
            illegal       <= d_illegal;
        end
    end

endmodule

// ==== decode/main_decoder.sv ====
module main_decoder (
    input  logic [5:0] op,
    input  logic [5:0] funct,
    output logic       reg_write,
    output logic       reg_dst,
    output logic [1:0] alu_src,
    output logic       branch,
    output logic       branch_ne,
    output logic [1:0] mem_size_wr,
    output logic       mem_to_reg,
    output logic [1:0] mem_size_rd,
    output logic       load_unsigned,
    output logic       jump,
    output logic       jump_reg,
    output logic       link,
    output logic [3:0] alu_op,
    output logic [3:0] fp_op,
    output logic       fp_reg_write,
    output logic       fp_mem_write,
    output logic       mem_to_fp,
    output logic       illegal
);
    import mips_pkg::*;

    // loads and stores share the size encoding in op[1:0]
    function automatic logic [1:0] access_size(input logic [1:0] sz);
        case (sz)
            2'b11:   return SIZE_WORD;
            2'b01:   return SIZE_HALF;
            default: return SIZE_BYTE;
        endcase
    endfunction

    always_comb begin
        reg_write     = 1'b0;
        reg_dst       = 1'b0;
        alu_src       = 2'd0;
        branch        = 1'b0;
        branch_ne     = 1'b0;
        mem_size_wr   = SIZE_NONE;
        mem_to_reg    = 1'b0;
        mem_size_rd   = SIZE_NONE;
        load_unsigned = 1'b0;
        jump          = 1'b0;
        jump_reg      = 1'b0;
        link          = 1'b0;
        alu_op        = '0;
        fp_op         = FP_NONE;
        fp_reg_write  = 1'b0;
        fp_mem_write  = 1'b0;
        mem_to_fp     = 1'b0;
        illegal       = 1'b0;
        case (op)
            OP_RTYPE: begin
                if (funct == FN_JR) begin
                    jump_reg = 1'b1;
                end else if (funct == FN_JALR) begin
                    jump_reg  = 1'b1;
                    link      = 1'b1;
                    reg_write = 1'b1;
                    reg_dst   = 1'b1;
                end else begin
                    reg_write = 1'b1;
                    reg_dst   = 1'b1;
                    alu_op    = ALU_RTYPE;
                end
            end
            OP_LW, OP_LH, OP_LB, OP_LHU, OP_LBU: begin
                reg_write     = 1'b1;
                mem_to_reg    = 1'b1;
                alu_src       = 2'd1;
                mem_size_rd   = access_size(op[1:0]);
                load_unsigned = op[2]; // lhu, lbu
            end
            OP_SW, OP_SH, OP_SB: begin
                alu_src     = 2'd1;
                mem_size_wr = access_size(op[1:0]);
            end
            OP_BEQ: begin
                branch = 1'b1;
            end
            OP_BNE: begin
                branch    = 1'b1;
                branch_ne = 1'b1;
            end
            OP_BLEZ, OP_BGTZ: begin
                branch = 1'b1;
                alu_op = (op == OP_BLEZ) ? ALU_LEZ : ALU_GTZ;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                reg_write = 1'b1;
                alu_src   = 2'd1;
                case (op)
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;
                    default:  alu_op = ALU_ADD;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                reg_write = 1'b1;
                alu_src   = 2'd2; // zero-extended imm
                case (op)
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    default: alu_op = ALU_LUI;
                endcase
            end
            OP_J: begin
                jump = 1'b1;
            end
            OP_JAL: begin
                jump      = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            OP_FP: begin
                fp_reg_write = 1'b1;
                case (funct)
                    FN_FADD: fp_op = FP_ADD;
                    FN_FSUB: fp_op = FP_SUB;
                    FN_FMUL: fp_op = FP_MUL;
                    FN_FDIV: fp_op = FP_DIV;
                    default: begin
                        fp_reg_write = 1'b0;
                        illegal      = 1'b1;
                    end
                endcase
            end
            OP_LWC1: begin
                alu_src      = 2'd1;
                mem_to_fp    = 1'b1;
                fp_reg_write = 1'b1;
            end
            OP_SWC1: begin
                alu_src      = 2'd1;
                fp_mem_write = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== sim/tb_decode_front.sv ====
module tb_decode_front;
    import mips_pkg::*;

    localparam logic [31:0] RESET_PC    = 32'h0040_0000; // low byte zero so imem can use addr[7:2]
    localparam int          QUEUE_DEPTH = 4;
    localparam int          MEM_WORDS   = 64;
    localparam int          TIMEOUT     = 100;

    // expected control word bits packed as in decoded_ctl()
    localparam logic [31:0] C_RW   = 32'h0000_0001;
    localparam logic [31:0] C_RDST = 32'h0000_0002;
    localparam logic [31:0] C_BR   = 32'h0000_0010;
    localparam logic [31:0] C_BNE  = 32'h0000_0020;
    localparam logic [31:0] C_M2R  = 32'h0000_0100;
    localparam logic [31:0] C_LU   = 32'h0000_0800;
    localparam logic [31:0] C_JMP  = 32'h0000_1000;
    localparam logic [31:0] C_JR   = 32'h0000_2000;
    localparam logic [31:0] C_LINK = 32'h0000_4000;
    localparam logic [31:0] C_FPRW = 32'h0080_0000;
    localparam logic [31:0] C_FPMW = 32'h0100_0000;
    localparam logic [31:0] C_M2F  = 32'h0200_0000;
    localparam logic [31:0] C_ILL  = 32'h0400_0000;

    logic        clk;
    logic        rst_n;
    logic        fetch_en;
    logic        hold;
    logic        redirect;
    logic [31:0] redirect_pc;
    instr_word_t imem_rdata;
    logic [31:0] imem_addr;
    logic        dec_valid;
    logic [31:0] dec_pc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;
    logic [31:0] imm;
    logic        reg_write;
    logic        reg_dst;
    logic [1:0]  alu_src;
    logic        branch;
    logic        branch_ne;
    logic [1:0]  mem_size_wr;
    logic        mem_to_reg;
    logic [1:0]  mem_size_rd;
    logic        load_unsigned;
    logic        jump;
    logic        jump_reg;
    logic        link;
    logic [3:0]  alu_op;
    logic [3:0]  fp_op;
    logic        fp_reg_write;
    logic        fp_mem_write;
    logic        mem_to_fp;
    logic        illegal;

    logic [31:0] imem     [MEM_WORDS];
    logic [31:0] exp_ctl  [MEM_WORDS];
    logic [4:0]  exp_dest [MEM_WORDS];
    logic [31:0] exp_imm  [MEM_WORDS];
    int          num_rows;
    logic [31:0] rng;
    logic        hold_random;

    decode_front #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) decode_front_i (
        .*
    );

    assign imem_rdata = imem[imem_addr[7:2]]; // combinational read

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rtype_word(input logic [5:0] op, input logic [4:0] f_rs,
                                               input logic [4:0] f_rt, input logic [4:0] f_rd,
                                               input logic [4:0] shamt, input logic [5:0] funct);
        return {op, f_rs, f_rt, f_rd, shamt, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] f_rs,
                                               input logic [4:0] f_rt, input logic [15:0] imm16);
        return {op, f_rs, f_rt, imm16};
    endfunction

    function automatic logic [31:0] alu_src_bits(input logic [1:0] v);
        return 32'(v) << 2;
    endfunction

    function automatic logic [31:0] store_size_bits(input logic [1:0] v);
        return 32'(v) << 6;
    endfunction

    function automatic logic [31:0] load_size_bits(input logic [1:0] v);
        return 32'(v) << 9;
    endfunction

    function automatic logic [31:0] alu_op_bits(input logic [3:0] v);
        return 32'(v) << 15;
    endfunction

    function automatic logic [31:0] fp_op_bits(input logic [3:0] v);
        return 32'(v) << 19;
    endfunction

    function automatic logic [31:0] decoded_ctl();
        return {5'd0, illegal, mem_to_fp, fp_mem_write, fp_reg_write, fp_op, alu_op,
                link, jump_reg, jump, load_unsigned, mem_size_rd, mem_to_reg, mem_size_wr,
                branch_ne, branch, alu_src, reg_dst, reg_write};
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        $display("Fail %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic add_row(input logic [31:0] word, input logic [4:0] d,
                           input logic [31:0] im, input logic [31:0] ctl);
        imem[num_rows]     = word;
        exp_dest[num_rows] = d;
        exp_imm[num_rows]  = im;
        exp_ctl[num_rows]  = ctl;
        num_rows++;
    endtask

    task automatic load_table();
        add_row(rtype_word(OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20), 5'd3, 32'h0000_1820,
                C_RW | C_RDST | alu_op_bits(ALU_RTYPE));
        add_row(rtype_word(OP_RTYPE, 5'd4, 5'd5, 5'd17, 5'd0, 6'h22), 5'd17, 32'hFFFF_8822,
                C_RW | C_RDST | alu_op_bits(ALU_RTYPE)); // rd field makes imm negative
        add_row(rtype_word(OP_RTYPE, 5'd31, 5'd0, 5'd0, 5'd0, FN_JR), 5'd0, 32'h0000_0008,
                C_JR);
        add_row(rtype_word(OP_RTYPE, 5'd9, 5'd0, 5'd5, 5'd0, FN_JALR), 5'd5, 32'h0000_2809,
                C_JR | C_LINK | C_RW | C_RDST);
        add_row(itype_word(OP_LW, 5'd29, 5'd8, 16'h0010), 5'd8, 32'h0000_0010,
                C_RW | C_M2R | alu_src_bits(2'd1) | load_size_bits(SIZE_WORD));
        add_row(itype_word(OP_LH, 5'd29, 5'd9, 16'hFFFC), 5'd9, 32'hFFFF_FFFC,
                C_RW | C_M2R | alu_src_bits(2'd1) | load_size_bits(SIZE_HALF));
        add_row(itype_word(OP_LB, 5'd4, 5'd10, 16'h0003), 5'd10, 32'h0000_0003,
                C_RW | C_M2R | alu_src_bits(2'd1) | load_size_bits(SIZE_BYTE));
        add_row(itype_word(OP_LHU, 5'd4, 5'd11, 16'h8000), 5'd11, 32'hFFFF_8000,
                C_RW | C_M2R | C_LU | alu_src_bits(2'd1) | load_size_bits(SIZE_HALF));
        add_row(itype_word(OP_LBU, 5'd4, 5'd12, 16'h0001), 5'd12, 32'h0000_0001,
                C_RW | C_M2R | C_LU | alu_src_bits(2'd1) | load_size_bits(SIZE_BYTE));
        add_row(itype_word(OP_SW, 5'd29, 5'd8, 16'h0020), 5'd8, 32'h0000_0020,
                alu_src_bits(2'd1) | store_size_bits(SIZE_WORD));
        add_row(itype_word(OP_SH, 5'd29, 5'd9, 16'hFFFE), 5'd9, 32'hFFFF_FFFE,
                alu_src_bits(2'd1) | store_size_bits(SIZE_HALF));
        add_row(itype_word(OP_SB, 5'd5, 5'd13, 16'h0007), 5'd13, 32'h0000_0007,
                alu_src_bits(2'd1) | store_size_bits(SIZE_BYTE));
        add_row(itype_word(OP_BEQ, 5'd1, 5'd2, 16'hFFFF), 5'd2, 32'hFFFF_FFFF, C_BR);
        add_row(itype_word(OP_BNE, 5'd1, 5'd2, 16'h0004), 5'd2, 32'h0000_0004, C_BR | C_BNE);
        add_row(itype_word(OP_BLEZ, 5'd3, 5'd0, 16'h0008), 5'd0, 32'h0000_0008,
                C_BR | alu_op_bits(ALU_LEZ));
        add_row(itype_word(OP_BGTZ, 5'd3, 5'd0, 16'hFFF0), 5'd0, 32'hFFFF_FFF0,
                C_BR | alu_op_bits(ALU_GTZ));
        add_row(itype_word(OP_ADDI, 5'd1, 5'd14, 16'h8001), 5'd14, 32'hFFFF_8001,
                C_RW | alu_src_bits(2'd1) | alu_op_bits(ALU_ADD));
        add_row(itype_word(OP_ADDIU, 5'd1, 5'd15, 16'h0100), 5'd15, 32'h0000_0100,
                C_RW | alu_src_bits(2'd1) | alu_op_bits(ALU_ADD));
        add_row(itype_word(OP_SLTI, 5'd2, 5'd16, 16'hFFFF), 5'd16, 32'hFFFF_FFFF,
                C_RW | alu_src_bits(2'd1) | alu_op_bits(ALU_SLT));
        add_row(itype_word(OP_SLTIU, 5'd2, 5'd17, 16'h0005), 5'd17, 32'h0000_0005,
                C_RW | alu_src_bits(2'd1) | alu_op_bits(ALU_SLTU));
        add_row(itype_word(OP_ANDI, 5'd3, 5'd18, 16'hF0F0), 5'd18, 32'h0000_F0F0,
                C_RW | alu_src_bits(2'd2) | alu_op_bits(ALU_AND)); // row 20, redirect target
        add_row(itype_word(OP_ORI, 5'd3, 5'd19, 16'h8000), 5'd19, 32'h0000_8000,
                C_RW | alu_src_bits(2'd2) | alu_op_bits(ALU_OR));
        add_row(itype_word(OP_XORI, 5'd3, 5'd20, 16'hFFFF), 5'd20, 32'h0000_FFFF,
                C_RW | alu_src_bits(2'd2) | alu_op_bits(ALU_XOR));
        add_row(itype_word(OP_LUI, 5'd0, 5'd21, 16'h1234), 5'd21, 32'h1234_0000,
                C_RW | alu_src_bits(2'd2) | alu_op_bits(ALU_LUI));
        add_row({OP_J, 26'h000_0040}, 5'd0, 32'h0000_0040, C_JMP);
        add_row({OP_JAL, 26'h012_3456}, 5'd31, 32'h0000_3456, C_JMP | C_LINK | C_RW);
        add_row(rtype_word(OP_FP, 5'd16, 5'd2, 5'd4, 5'd6, FN_FADD), 5'd2, 32'h0000_2180,
                C_FPRW | fp_op_bits(FP_ADD));
        add_row(rtype_word(OP_FP, 5'd16, 5'd3, 5'd5, 5'd7, FN_FSUB), 5'd3, 32'h0000_29C1,
                C_FPRW | fp_op_bits(FP_SUB));
        add_row(rtype_word(OP_FP, 5'd16, 5'd4, 5'd6, 5'd8, FN_FMUL), 5'd4, 32'h0000_3202,
                C_FPRW | fp_op_bits(FP_MUL));
        add_row(rtype_word(OP_FP, 5'd16, 5'd5, 5'd7, 5'd9, FN_FDIV), 5'd5, 32'h0000_3A43,
                C_FPRW | fp_op_bits(FP_DIV));
        add_row(itype_word(OP_LWC1, 5'd29, 5'd6, 16'hFFF8), 5'd6, 32'hFFFF_FFF8,
                C_M2F | C_FPRW | alu_src_bits(2'd1));
        add_row(itype_word(OP_SWC1, 5'd29, 5'd7, 16'h000C), 5'd7, 32'h0000_000C,
                C_FPMW | alu_src_bits(2'd1));
        add_row(itype_word(6'h3F, 5'd1, 5'd2, 16'h0001), 5'd2, 32'h0000_0001, C_ILL);
        add_row(rtype_word(OP_FP, 5'd16, 5'd1, 5'd2, 5'd0, 6'h3F), 5'd1, 32'h0000_103F,
                C_ILL); // unlisted fp funct
        add_row(itype_word(6'h12, 5'd0, 5'd3, 16'h8000), 5'd3, 32'hFFFF_8000, C_ILL);
    endtask

    // returns right after the falling edge where dec_valid was seen
    task automatic wait_valid();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = dec_valid;
            cycles++;
            if (hold_random) begin
                rng  = next_random(rng);
                hold = rng[16];
            end
            if (!seen && cycles >= TIMEOUT) begin
                $display("timeout: no decoded instruction within %0d cycles", TIMEOUT);
                abort_run();
            end
        end
    endtask

    task automatic check_row(input int k);
        logic [31:0] want_pc;
        logic [4:0]  want_rs;
        logic [4:0]  want_rt;
        want_pc = RESET_PC + 32'(4 * k);
        want_rs = imem[k][25:21]; // rs and rt fields of the table word
        want_rt = imem[k][20:16];
        assert (dec_pc == want_pc)
            else report_mismatch($sformatf("dec_pc %h, expected %h", dec_pc, want_pc));
        assert (decoded_ctl() == exp_ctl[k])
            else report_mismatch($sformatf("row %0d controls %h, expected %h",
                                           k, decoded_ctl(), exp_ctl[k]));
        assert (rs == want_rs)
            else report_mismatch($sformatf("row %0d rs %0d, expected %0d", k, rs, want_rs));
        assert (rt == want_rt)
            else report_mismatch($sformatf("row %0d rt %0d, expected %0d", k, rt, want_rt));
        assert (dest == exp_dest[k])
            else report_mismatch($sformatf("row %0d dest %0d, expected %0d",
                                           k, dest, exp_dest[k]));
        assert (imm == exp_imm[k])
            else report_mismatch($sformatf("row %0d imm %h, expected %h", k, imm, exp_imm[k]));
    endtask

    task automatic walk_table(input int first);
        for (int k = first; k < num_rows; k++) begin
            wait_valid();
            check_row(k);
        end
    endtask

    task automatic check_full_stall();
        logic [31:0] stall_addr;
        hold = 1'b1;
        repeat (QUEUE_DEPTH + 2) begin
            @(negedge clk);
            assert (!dec_valid) else report_mismatch("dec_valid high while hold is set");
        end
        stall_addr = imem_addr; // queue is full by now
        repeat (4) begin
            @(negedge clk);
            assert (imem_addr == stall_addr)
                else report_mismatch($sformatf("imem_addr moved to %h while queue full",
                                               imem_addr));
            assert (!dec_valid) else report_mismatch("dec_valid high while hold is set");
        end
    endtask

    task automatic restart(input int row);
        redirect    = 1'b1;
        redirect_pc = RESET_PC + 32'(4 * row);
        @(negedge clk);
        redirect = 1'b0;
        assert (!dec_valid) else report_mismatch("dec_valid high right after redirect");
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_en    = 1'b0;
        hold        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        hold_random = 1'b0;
        rng         = 32'h2262;
        num_rows    = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (RESET_PC + 32'(4 * i)) ^ 32'h5A5A_C3C3; // fill past the table
        end
        load_table();

        repeat (10) @(negedge clk);
        assert (imem_addr == RESET_PC)
            else report_mismatch($sformatf("imem_addr %h in reset", imem_addr));
        assert (!dec_valid) else report_mismatch("dec_valid high in reset");
        rst_n    = 1'b1;
        fetch_en = 1'b1;

        walk_table(0);
        check_full_stall();

        hold_random = 1'b1; // same program again under random stalls
        restart(0);
        walk_table(0);

        hold_random = 1'b0;
        hold        = 1'b0;
        restart(20);
        walk_table(20);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== tb.f ====
common/mips_pkg.sv
decode/main_decoder.sv
decode/decode_stage.sv
verilog/fetch_unit.sv
verilog/instr_queue.sv
verilog/decode_front.sv
sim/tb_decode_front.sv

// ==== verilog/decode_front.sv ====
module decode_front #(
    parameter logic [31:0] RESET_PC    = 32'h0040_0000,
    parameter int          QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_en,
    input  logic                  hold,
    input  logic                  redirect,
    input  logic [31:0]           redirect_pc,
    input  mips_pkg::instr_word_t imem_rdata,
    output logic [31:0]           imem_addr,
    output logic                  dec_valid,
    output logic [31:0]           dec_pc,
    output logic [4:0]            rs,
    output logic [4:0]            rt,
    output logic [4:0]            dest,
    output logic [31:0]           imm,
    output logic                  reg_write,
    output logic                  reg_dst,
    output logic [1:0]            alu_src,
    output logic                  branch,
    output logic                  branch_ne,
    output logic [1:0]            mem_size_wr,
    output logic                  mem_to_reg,
    output logic [1:0]            mem_size_rd,
    output logic                  load_unsigned,
    output logic                  jump,
    output logic                  jump_reg,
    output logic                  link,
    output logic [3:0]            alu_op,
    output logic [3:0]            fp_op,
    output logic                  fp_reg_write,
    output logic                  fp_mem_write,
    output logic                  mem_to_fp,
    output logic                  illegal
);
    import mips_pkg::*;

    logic        push;
    logic        pop;
    logic        full;
    logic        empty;
    instr_word_t push_instr;
    instr_word_t pop_instr;
    logic [31:0] push_pc;
    logic [31:0] pop_pc;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_rdata  (imem_rdata),
        .full        (full),
        .imem_addr   (imem_addr),
        .push        (push),
        .push_instr  (push_instr),
        .push_pc     (push_pc)
    );

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) instr_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect),
        .push       (push),
        .push_instr (push_instr),
        .push_pc    (push_pc),
        .pop        (pop),
        .pop_instr  (pop_instr),
        .pop_pc     (pop_pc),
        .full       (full),
        .empty      (empty)
    );

    // remaining ports match by name
    decode_stage decode_stage_i (
        .flush (redirect),
        .*
    );

endmodule

// ==== verilog/fetch_unit.sv ====
module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0040_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_en,
    input  logic                  redirect,
    input  logic [31:0]           redirect_pc,
    input  mips_pkg::instr_word_t imem_rdata,
    input  logic                  full,
    output logic [31:0]           imem_addr,
    output logic                  push,
    output mips_pkg::instr_word_t push_instr,
    output logic [31:0]           push_pc
);

    logic [31:0] pc;

    assign imem_addr  = pc;
    assign push       = fetch_en && !full && !redirect; // word fetched during redirect is dropped
    assign push_instr = imem_rdata;
    assign push_pc    = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (push) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

// ==== verilog/instr_queue.sv ====
module instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  push,
    input  mips_pkg::instr_word_t push_instr,
    input  logic [31:0]           push_pc,
    input  logic                  pop,
    output mips_pkg::instr_word_t pop_instr,
    output logic [31:0]           pop_pc,
    output logic                  full,
    output logic                  empty
);
    import mips_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    instr_word_t      instr_mem [QUEUE_DEPTH];
    logic [31:0]      pc_mem    [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == (PTR_W + 1)'(QUEUE_DEPTH));
    assign empty     = (count == '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign pop_instr = instr_mem[rd_ptr]; // oldest entry
    assign pop_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
